/* project.f */
boardPkg.sv
lcdPkg.sv
tickGen.sv
inputDebouncer.sv
buttonDecoder.sv
snapshotFormatter.sv
lcdDriver.sv
cpuTestHarness.sv
harnessTb.sv

/* Bender.yml */
package:
  name: cpu_test_harness

sources:
  - boardPkg.sv
  - lcdPkg.sv
  - tickGen.sv
  - inputDebouncer.sv
  - buttonDecoder.sv
  - snapshotFormatter.sv
  - lcdDriver.sv
  - cpuTestHarness.sv
  - target: test
    files:
      - harnessTb.sv

/* harnessTb.sv */
`timescale 1ns/10ps

module harnessTb;

    logic USER_CLK;
    logic reset;
    logic [boardPkg::NUM_SWITCHES-1:0] switches;
    boardPkg::cpuStatus status;
    boardPkg::cpuControl control;
    logic phi0;
    lcdPkg::lcdBus lcd;
    logic [7:0] ledLow;
    logic ledN;
    logic ledW;

    logic [31:0] rngState = 32'hcfd9ac89;
    logic [8:0] rxQ[$];        // decoded bytes, rs in bit 8
    logic [8:0] expQ[$];       // model output
    int errors = 0;
    int checks = 0;
    int testErrs = 0;
    int testCount = 0;

    // lcd bus decoder state
    logic prevE;
    int nibblesSeen;
    logic haveHigh;
    logic [3:0] highNib;

    cpuTestHarness DUT (
        .USER_CLK (USER_CLK),
        .reset    (reset),
        .switches (switches),
        .status   (status),
        .control  (control),
        .phi0     (phi0),
        .lcd      (lcd),
        .ledLow   (ledLow),
        .ledN     (ledN),
        .ledW     (ledW)
    );

    initial begin
        USER_CLK = 1'b0;
        forever #5 USER_CLK = ~USER_CLK;
    end

    // watchdog over the whole run
    initial begin
        repeat (100000) @(posedge USER_CLK);
        $display("ERROR: simulation did not complete within the cycle limit");
        $display("Result: FAILED");
        $finish;
    end

    // nibble read one cycle after e falls while rs and data still hold
    always @(posedge USER_CLK) begin
        if (reset) begin
            prevE <= 1'b0;
            nibblesSeen <= 0;
            haveHigh <= 1'b0;
        end else begin
            prevE <= lcd.e;
            if (prevE && !lcd.e) begin
                compareValue("lcd rw", 0, lcd.rw);
                if (nibblesSeen < 4) begin   // wake-up nibbles travel alone
                    rxQ.push_back({lcd.rs, lcd.data, 4'h0});
                    nibblesSeen <= nibblesSeen + 1;
                end else if (!haveHigh) begin
                    highNib <= lcd.data;
                    haveHigh <= 1'b1;
                end else begin
                    rxQ.push_back({lcd.rs, highNib, lcd.data});
                    haveHigh <= 1'b0;
                end
            end
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic logic [7:0] hexAscii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + 8'(nib);
        end
        return 8'h41 + 8'(nib - 4'd10);
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
            testErrs++;
        end
    endtask

    task automatic reportWait(input string what);
        $display("ERROR: timed out waiting for %s", what);
        errors++;
        testErrs++;
    endtask

    task automatic waitBytes(input int n, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (rxQ.size() < n && cycles < limit) begin
            @(posedge USER_CLK);
            cycles++;
        end
        if (rxQ.size() < n) reportWait($sformatf("%0d LCD bytes in %s", n, what));
    endtask

    task automatic waitInitDone(input int limit);
        int cycles;
        cycles = 0;
        while (!ledW && cycles < limit) begin
            @(posedge USER_CLK);
            cycles++;
        end
        if (!ledW) reportWait("the LCD ready LED");
    endtask

    task automatic waitIdle(input int limit);
        int cycles;
        cycles = 0;
        while (DUT.formatterBusy && cycles < limit) begin
            @(posedge USER_CLK);
            cycles++;
        end
        if (DUT.formatterBusy) reportWait("the formatter to go idle");
    endtask

    // home, then tag, two hex digits and a space per register
    task automatic expectDisplay();
        logic [7:0] regs [4];
        logic [7:0] tag;
        regs[0] = status.accum;
        regs[1] = status.xReg;
        regs[2] = status.yReg;
        regs[3] = status.opcode;
        expQ.push_back(9'h080);
        for (int f = 0; f < 4; f++) begin
            case (f)
                0: tag = 8'h41;
                1: tag = 8'h58;
                2: tag = 8'h59;
                default: tag = 8'h4F;
            endcase
            expQ.push_back({1'b1, tag});
            expQ.push_back({1'b1, hexAscii(regs[f][7:4])});
            expQ.push_back({1'b1, hexAscii(regs[f][3:0])});
            expQ.push_back(9'h120);
        end
    endtask

    task automatic checkStream(input string name, input int limit);
        logic [8:0] got;
        logic [8:0] want;
        int idx;
        idx = 0;
        waitBytes(expQ.size(), limit, name);
        while (expQ.size() > 0) begin
            want = expQ.pop_front();
            got = (rxQ.size() > 0) ? rxQ.pop_front() : 9'bx;
            compareValue($sformatf("%s byte %0d", name, idx), want, got);
            idx++;
        end
    endtask

    // press well past the debounce window, then release the same way
    task automatic pressButton(input int idx);
        @(posedge USER_CLK);
        switches[idx] <= 1'b1;
        repeat (40) @(posedge USER_CLK);
        switches[idx] <= 1'b0;
        repeat (40) @(posedge USER_CLK);
    endtask

    task automatic checkQuiet(input string name);
        waitIdle(2000);
        repeat (60) @(posedge USER_CLK);
        compareValue({name, " extra bytes"}, 0, rxQ.size());
        rxQ.delete();
    endtask

    task automatic setRandomStatus();
        logic [31:0] r;
        r = nextRand();
        @(posedge USER_CLK);
        status.accum <= r[7:0];
        status.xReg <= r[15:8];
        status.yReg <= r[23:16];
        status.opcode <= r[31:24];
        @(posedge USER_CLK);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s: %s", testCount, name, (testErrs == 0) ? "ok" : "errors");
        testErrs = 0;
    endtask

    initial begin
        logic [31:0] r;
        int phiCount;
        boardPkg::cpuControl expCtrl;
        reset = 1'b1;
        switches = '0;
        status = '0;
        repeat (10) @(posedge USER_CLK);
        reset <= 1'b0;
        @(posedge USER_CLK);
        @(posedge USER_CLK);

        compareValue("reset e", 0, lcd.e);
        compareValue("reset rs", 0, lcd.rs);
        compareValue("reset control", 0, control);
        expQ = '{9'h030, 9'h030, 9'h030, 9'h020, 9'h028, 9'h006, 9'h00C, 9'h001};
        checkStream("init", 5000);
        waitInitDone(500);
        finishTest("reset and init");

        setRandomStatus();
        expectDisplay();
        pressButton(boardPkg::SW_DISPLAY);
        checkStream("display", 3000);
        checkQuiet("display");
        finishTest("display snapshot");

        expQ.push_back(9'h001);
        pressButton(boardPkg::SW_CLEAR);
        checkStream("clear", 2000);
        checkQuiet("clear");
        finishTest("clear");

        for (int g = 0; g < 12; g++) begin
            r = nextRand();
            @(posedge USER_CLK);
            switches[boardPkg::SW_DISPLAY] <= 1'b1;
            repeat (1 + r[2:0]) @(posedge USER_CLK);     // covers at most two samples
            switches[boardPkg::SW_DISPLAY] <= 1'b0;
            repeat (8 + r[5:3]) @(posedge USER_CLK);
        end
        repeat (300) @(posedge USER_CLK);
        compareValue("glitch bytes", 0, rxQ.size());
        for (int d = 0; d < 4; d++) begin
            r = nextRand();
            @(posedge USER_CLK);
            switches[7:4] <= r[3:0];   // rdy, irq, nmi, res dips
            repeat (40) @(posedge USER_CLK);
            expCtrl = '{rdy: r[0], irqL: r[1], nmiL: r[2], resL: r[3], so: 1'b0};
            compareValue($sformatf("dip control %0d", d), expCtrl, control);
        end
        finishTest("debounce rejection");

        for (int m = 0; m < 4; m++) begin
            r = nextRand();
            @(posedge USER_CLK);
            status.addrLow <= r[7:0];
            status.sync <= r[8];
            @(posedge USER_CLK);
            compareValue("ledLow", r[7:0], ledLow);
            compareValue("ledN", r[8], ledN);
        end
        for (int w = 0; w < 4; w++) begin
            phiCount = 0;
            repeat (boardPkg::PHI_DIV) begin
                @(posedge USER_CLK);
                if (phi0) phiCount++;
            end
            compareValue($sformatf("phi0 window %0d", w), 1, phiCount);
        end
        finishTest("mirroring and pacing");

        for (int p = 0; p < 6; p++) begin
            setRandomStatus();
            r = nextRand();
            if (r[16]) begin
                expQ.push_back(9'h001);
                pressButton(boardPkg::SW_CLEAR);
            end else begin
                expectDisplay();
                pressButton(boardPkg::SW_DISPLAY);
            end
            checkStream($sformatf("press %0d", p), 3000);
            checkQuiet($sformatf("press %0d", p));
        end
        finishTest("repeated presses");

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* cpuTestHarness.sv */
`timescale 1ns/10ps

module cpuTestHarness (
    input  logic                              USER_CLK,
    input  logic                              reset,
    input  logic [boardPkg::NUM_SWITCHES-1:0] switches,
    input  boardPkg::cpuStatus                status,
    output boardPkg::cpuControl               control,
    output logic                              phi0,
    output lcdPkg::lcdBus                     lcd,
    output logic [7:0]                        ledLow,
    output logic                              ledN,
    output logic                              ledW
);

    logic sampleTick;
    logic [boardPkg::NUM_SWITCHES-1:0] debounced;
    logic displayReq;
    logic clearReq;
    logic lcdReset;
    logic writeStart;
    logic writeDone;
    logic initDone;
    logic formatterBusy;     // probed by the testbench
    lcdPkg::lcdWrite lcdWord;

    tickGen ticks (
        .USER_CLK   (USER_CLK),
        .reset      (reset),
        .sampleTick (sampleTick),
        .phiTick    (phi0)
    );

    // one debouncer per button and dip switch
    for (genvar i = 0; i < boardPkg::NUM_SWITCHES; i++) begin : gDebounce
        inputDebouncer deb (
            .USER_CLK   (USER_CLK),
            .reset      (reset),
            .sampleTick (sampleTick),
            .raw        (switches[i]),
            .stable     (debounced[i])
        );
    end

    buttonDecoder decoder (
        .USER_CLK   (USER_CLK),
        .reset      (reset),
        .switches   (debounced),
        .displayReq (displayReq),
        .clearReq   (clearReq),
        .lcdReset   (lcdReset),
        .control    (control)
    );

    snapshotFormatter formatter (
        .USER_CLK   (USER_CLK),
        .reset      (reset),
        .displayReq (displayReq),
        .clearReq   (clearReq),
        .status     (status),
        .initDone   (initDone),
        .writeDone  (writeDone),
        .writeStart (writeStart),
        .write      (lcdWord),
        .busy       (formatterBusy)
    );

    lcdDriver panel (
        .USER_CLK   (USER_CLK),
        .reset      (reset),
        .lcdReset   (lcdReset),
        .writeStart (writeStart),
        .write      (lcdWord),
        .writeDone  (writeDone),
        .initDone   (initDone),
        .bus        (lcd)
    );

    assign ledLow = status.addrLow;
    assign ledN = status.sync;
    assign ledW = initDone;     // lit once the panel is ready

endmodule

/* lcdDriver.sv */
`timescale 1ns/10ps

module lcdDriver (
    input  logic            USER_CLK,
    input  logic            reset,
    input  logic            lcdReset,
    input  logic            writeStart,
    input  lcdPkg::lcdWrite write,
    output logic            writeDone,
    output logic            initDone,
    output lcdPkg::lcdBus   bus
);

    typedef enum logic [2:0] {
        ST_POWER,
        ST_SETUP,
        ST_PULSE,
        ST_HOLD,
        ST_IDLE
    } drvState;

    drvState state;
    logic [lcdPkg::WAIT_W-1:0] waitCnt;
    lcdPkg::lcdWrite cur;      // byte on the bus
    logic lowPhase;            // low nibble in flight
    logic [2:0] initStep;
    logic singleNibble;
    logic isClear;

    // power-up script, first four entries send only their high nibble
    function automatic lcdPkg::lcdWrite initEntry(input logic [2:0] step);
        lcdPkg::lcdWrite entry;
        entry.isData = 1'b0;
        case (step)
            3'd0, 3'd1, 3'd2: entry.value = 8'h30;   // wake up in 8-bit mode
            3'd3: entry.value = 8'h20;               // now 4-bit
            3'd4: entry.value = lcdPkg::CMD_FUNCTION;
            3'd5: entry.value = lcdPkg::CMD_ENTRY;
            3'd6: entry.value = lcdPkg::CMD_DISPLAY_ON;
            default: entry.value = lcdPkg::CMD_CLEAR;
        endcase
        return entry;
    endfunction

    assign singleNibble = !initDone && !initStep[2];
    assign isClear = !cur.isData && (cur.value == lcdPkg::CMD_CLEAR);

    assign bus.rs = cur.isData;
    assign bus.rw = 1'b0;                  // write only, busy flag never read
    assign bus.e = (state == ST_PULSE);
    assign bus.data = lowPhase ? cur.value[3:0] : cur.value[7:4];

    always_ff @(posedge USER_CLK) begin
        if (reset || lcdReset) begin
            state <= ST_POWER;
            waitCnt <= lcdPkg::POWER_WAIT - 1'b1;
            cur <= '0;
            lowPhase <= 1'b0;
            initStep <= '0;
            initDone <= 1'b0;
            writeDone <= 1'b0;
        end else begin
            writeDone <= 1'b0;
            case (state)
                ST_POWER: begin
                    if (waitCnt == '0) begin
                        cur <= initEntry(initStep);
                        state <= ST_SETUP;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                ST_SETUP: begin   // rs and data settle with e low
                    waitCnt <= lcdPkg::E_PULSE - 1'b1;
                    state <= ST_PULSE;
                end
                ST_PULSE: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else begin
                        if (!lowPhase && !singleNibble) begin
                            waitCnt <= lcdPkg::NIBBLE_GAP - 1'b1;
                        end else if (isClear) begin
                            waitCnt <= lcdPkg::CLEAR_WAIT - 1'b1;
                        end else begin
                            waitCnt <= lcdPkg::BYTE_WAIT - 1'b1;
                        end
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else if (!lowPhase && !singleNibble) begin
                        lowPhase <= 1'b1;          // second half of the byte
                        state <= ST_SETUP;
                    end else if (initDone) begin
                        writeDone <= 1'b1;
                        state <= ST_IDLE;
                    end else if (initStep == 3'd7) begin
                        initDone <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        initStep <= initStep + 3'd1;
                        cur <= initEntry(initStep + 3'd1);
                        lowPhase <= 1'b0;
                        state <= ST_SETUP;
                    end
                end
                ST_IDLE: begin
                    if (writeStart) begin
                        cur <= write;
                        lowPhase <= 1'b0;
                        state <= ST_SETUP;
                    end
                end
                default: state <= ST_POWER;
            endcase
        end
    end

    // enable width seen on the pin
    ePulseWidth: assert property (@(posedge USER_CLK) disable iff (reset || lcdReset)
        $rose(bus.e) |-> bus.e [*lcdPkg::E_PULSE] ##1 !bus.e);

endmodule

/* snapshotFormatter.sv */
`timescale 1ns/10ps

module snapshotFormatter (
    input  logic               USER_CLK,
    input  logic               reset,
    input  logic               displayReq,
    input  logic               clearReq,
    input  boardPkg::cpuStatus status,
    input  logic               initDone,
    input  logic               writeDone,
    output logic               writeStart,
    output lcdPkg::lcdWrite    write,
    output logic               busy
);

    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_ISSUE,
        FMT_WAIT
    } fmtState;

    fmtState state;
    logic [3:0][7:0] snap;                       // accum, x, y, opcode from index 0 up
    logic [lcdPkg::CHAR_IDX_W-1:0] charIdx;      // next character on the line
    logic lastWrite;

    function automatic logic [7:0] hexChar(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};          // '0'..'9'
        end
        return 8'h37 + {4'h0, nib};              // 'A'..'F'
    endfunction

    // four fields of four chars: tag, two hex digits, space
    function automatic logic [7:0] lineChar(input logic [lcdPkg::CHAR_IDX_W-1:0] idx,
                                            input logic [3:0][7:0] regs);
        logic [7:0] field;
        logic [7:0] tag;
        field = regs[idx[3:2]];
        case (idx[3:2])
            2'd0: tag = 8'h41;    // A
            2'd1: tag = 8'h58;    // X
            2'd2: tag = 8'h59;    // Y
            default: tag = 8'h4F; // O
        endcase
        case (idx[1:0])
            2'd0: return tag;
            2'd1: return hexChar(field[7:4]);
            2'd2: return hexChar(field[3:0]);
            default: return 8'h20;
        endcase
    endfunction

    assign writeStart = (state == FMT_ISSUE);
    assign busy = (state != FMT_IDLE);

    always_ff @(posedge USER_CLK) begin
        if (reset) begin
            state <= FMT_IDLE;
            charIdx <= '0;
            lastWrite <= 1'b0;
        end else if (!initDone) begin
            state <= FMT_IDLE;   // panel restarting, the transfer is lost
        end else begin
            case (state)
                FMT_IDLE: begin
                    if (clearReq) begin   // clear beats display
                        write <= '{isData: 1'b0, value: lcdPkg::CMD_CLEAR};
                        lastWrite <= 1'b1;
                        state <= FMT_ISSUE;
                    end else if (displayReq) begin
                        snap <= {status.opcode, status.yReg, status.xReg, status.accum};
                        write <= '{isData: 1'b0, value: lcdPkg::CMD_HOME};
                        charIdx <= '0;
                        lastWrite <= 1'b0;
                        state <= FMT_ISSUE;
                    end
                end
                FMT_ISSUE: state <= FMT_WAIT;
                FMT_WAIT: begin
                    if (writeDone) begin
                        if (lastWrite) begin
                            state <= FMT_IDLE;
                        end else begin
                            write <= '{isData: 1'b1, value: lineChar(charIdx, snap)};
                            lastWrite <= (charIdx == lcdPkg::CHAR_LAST);
                            charIdx <= charIdx + 1'b1;
                            state <= FMT_ISSUE;
                        end
                    end
                end
                default: state <= FMT_IDLE;
            endcase
        end
    end

    // the driver takes one byte at a time
    oneWriteInFlight: assert property (@(posedge USER_CLK) disable iff (reset || !initDone)
        writeStart |=> !writeStart until writeDone);

endmodule

/* buttonDecoder.sv */
`timescale 1ns/10ps

module buttonDecoder (
    input  logic                              USER_CLK,
    input  logic                              reset,
    input  logic [boardPkg::NUM_SWITCHES-1:0] switches,
    output logic                              displayReq,
    output logic                              clearReq,
    output logic                              lcdReset,
    output boardPkg::cpuControl               control
);

    logic displayPrev;
    logic clearPrev;

    always_ff @(posedge USER_CLK) begin
        if (reset) begin
            displayPrev <= 1'b0;
            clearPrev <= 1'b0;
            displayReq <= 1'b0;
            clearReq <= 1'b0;
            lcdReset <= 1'b0;
            control <= '0;     // resL low keeps the core in reset
        end else begin
            displayPrev <= switches[boardPkg::SW_DISPLAY];
            clearPrev <= switches[boardPkg::SW_CLEAR];

            // press edges only
            displayReq <= switches[boardPkg::SW_DISPLAY] & ~displayPrev;
            clearReq <= switches[boardPkg::SW_CLEAR] & ~clearPrev;

            lcdReset <= switches[boardPkg::SW_LCDRESET];

            // dip switches drive the pins as levels
            control.rdy <= switches[boardPkg::SW_RDY];
            control.irqL <= switches[boardPkg::SW_IRQ];
            control.nmiL <= switches[boardPkg::SW_NMI];
            control.resL <= switches[boardPkg::SW_RES];
            control.so <= switches[boardPkg::SW_SO];   // set overflow, momentary
        end
    end

    // debounced edges share one sample strobe, so requests never come back to back
    noBackToBack: assert property (@(posedge USER_CLK) disable iff (reset)
        (displayReq || clearReq) |=> !(displayReq || clearReq));

endmodule

/* inputDebouncer.sv */
`timescale 1ns/10ps

module inputDebouncer (
    input  logic USER_CLK,
    input  logic reset,
    input  logic sampleTick,
    input  logic raw,
    output logic stable
);

    logic syncA;
    logic syncB;
    logic [boardPkg::DEBOUNCE_W-1:0] agreeCnt;   // samples that disagree with stable

    always_ff @(posedge USER_CLK) begin
        if (reset) begin
            syncA <= 1'b0;
            syncB <= 1'b0;
            agreeCnt <= '0;
            stable <= 1'b0;
        end else begin
            syncA <= raw;      // raw pin is asynchronous
            syncB <= syncA;
            if (sampleTick) begin
                if (syncB == stable) begin
                    agreeCnt <= '0;    // bounce back, start over
                end else if (agreeCnt == boardPkg::DEBOUNCE_LAST) begin
                    stable <= syncB;
                    agreeCnt <= '0;
                end else begin
                    agreeCnt <= agreeCnt + 1'b1;
                end
            end
        end
    end

    // new level only ever lands right after a sample strobe
    stableFollowsTick: assert property (@(posedge USER_CLK) disable iff (reset)
        $changed(stable) |-> $past(sampleTick));

endmodule

/* tickGen.sv */
`timescale 1ns/10ps

module tickGen (
    input  logic USER_CLK,
    input  logic reset,
    output logic sampleTick,
    output logic phiTick
);

    logic [boardPkg::SAMPLE_W-1:0] sampleCnt;
    logic [boardPkg::PHI_W-1:0] phiCnt;

    // both dividers restart together when reset drops
    always_ff @(posedge USER_CLK) begin
        if (reset) begin
            sampleCnt <= '0;
            phiCnt <= '0;
        end else begin
            if (sampleCnt == boardPkg::SAMPLE_LAST) begin
                sampleCnt <= '0;
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end

            if (phiCnt == boardPkg::PHI_LAST) begin
                phiCnt <= '0;
            end else begin
                phiCnt <= phiCnt + 1'b1;
            end
        end
    end

    assign sampleTick = (sampleCnt == boardPkg::SAMPLE_LAST);  // debounce sample strobe
    assign phiTick = (phiCnt == boardPkg::PHI_LAST);            // one processor phase

endmodule

/* lcdPkg.sv */
package lcdPkg;

    localparam int unsigned WAIT_W = 16;

    // all waits in USER_CLK cycles, scaled down for simulation
    localparam logic [WAIT_W-1:0] POWER_WAIT = 16'd100;
    localparam logic [WAIT_W-1:0] E_PULSE = 16'd4;
    localparam logic [WAIT_W-1:0] NIBBLE_GAP = 16'd3;
    localparam logic [WAIT_W-1:0] BYTE_WAIT = 16'd12;
    localparam logic [WAIT_W-1:0] CLEAR_WAIT = 16'd40;   // clear takes far longer on the panel

    localparam logic [7:0] CMD_FUNCTION = 8'h28;     // 4-bit bus, two lines, 5x8 font
    localparam logic [7:0] CMD_ENTRY = 8'h06;        // increment, no shift
    localparam logic [7:0] CMD_DISPLAY_ON = 8'h0C;   // cursor and blink off
    localparam logic [7:0] CMD_CLEAR = 8'h01;
    localparam logic [7:0] CMD_HOME = 8'h80;         // ddram address 0

    localparam int unsigned LINE_CHARS = 16;
    localparam int unsigned CHAR_IDX_W = $clog2(LINE_CHARS);
    localparam logic [CHAR_IDX_W-1:0] CHAR_LAST = CHAR_IDX_W'(LINE_CHARS - 1);

    // one byte for the panel
    typedef struct packed {
        logic       isData;   // selects rs
        logic [7:0] value;
    } lcdWrite;

    // pins of the character module
    typedef struct packed {
        logic       rs;
        logic       rw;
        logic       e;
        logic [3:0] data;     // db7..db4
    } lcdBus;

endpackage

/* boardPkg.sv */
package boardPkg;

    localparam int unsigned NUM_SWITCHES = 8;      // 4 push buttons and 4 dip switches
    localparam int unsigned SAMPLE_DIV = 4;        // kept short for simulation
    localparam int unsigned DEBOUNCE_SAMPLES = 4;
    localparam int unsigned PHI_DIV = 64;

    // counter widths and terminal counts
    localparam int unsigned SAMPLE_W = $clog2(SAMPLE_DIV);
    localparam int unsigned PHI_W = $clog2(PHI_DIV);
    localparam int unsigned DEBOUNCE_W = $clog2(DEBOUNCE_SAMPLES);
    localparam logic [SAMPLE_W-1:0] SAMPLE_LAST = SAMPLE_W'(SAMPLE_DIV - 1);
    localparam logic [PHI_W-1:0] PHI_LAST = PHI_W'(PHI_DIV - 1);
    localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_LAST = DEBOUNCE_W'(DEBOUNCE_SAMPLES - 1);

    // position of each input in the switch vector
    localparam int unsigned SW_DISPLAY = 0;    // north button
    localparam int unsigned SW_CLEAR = 1;      // east button
    localparam int unsigned SW_SO = 2;         // south button
    localparam int unsigned SW_LCDRESET = 3;   // west button
    localparam int unsigned SW_RDY = 4;        // dip 1
    localparam int unsigned SW_IRQ = 5;        // dip 2
    localparam int unsigned SW_NMI = 6;        // dip 3
    localparam int unsigned SW_RES = 7;        // dip 4

    typedef struct packed {
        logic [7:0] accum;
        logic [7:0] xReg;
        logic [7:0] yReg;
        logic [7:0] opcode;
        logic [7:0] addrLow;
        logic       sync;
    } cpuStatus;

    // active-low names follow the 6502 pins
    typedef struct packed {
        logic rdy;
        logic irqL;
        logic nmiL;
        logic resL;
        logic so;
    } cpuControl;

endpackage
